// File: source/aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Width of one loaded key or text word
`define AES_WORD_W 32

// Columns per 128-bit block
`define AES_BLOCK_WORDS 4

// Expanded-key words held, round keys 0 and 1
`define AES_KEY_WORDS 8

// Register stages in the round core
`define AES_PIPE_STAGES 3

`endif

// File: source/aesTypesPkg.sv
`include "aes_config.svh"

package aesTypesPkg;

        typedef logic [7:0] aesByteT;

        typedef logic [`AES_WORD_W-1:0] aesWordT;

        ////////////////////////////////////////////////////////////
        // State word, viewed as columns or as bytes
        ////////////////////////////////////////////////////////////

        // Column 0 sits in the top bits, so byte 4c+r is row r of column c
        typedef union packed {
                aesWordT [0:`AES_BLOCK_WORDS-1] cols;
                aesByteT [0:`AES_BLOCK_WORDS*`AES_WORD_W/8-1] bytes;
        } aesStateT;

endpackage

// File: source/aesTablesPkg.sv
package aesTablesPkg;

        import aesTypesPkg::*;

        // Forward S-box
        localparam aesByteT aesSbox [256] = '{
                8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
                8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
                8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
                8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
                8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
                8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
                8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
                8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
                8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
                8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
                8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
                8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
                8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
                8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
                8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
                8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
                8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
                8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
                8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
                8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
                8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
                8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
                8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
                8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
                8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
                8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
                8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
                8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
                8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
                8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
                8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
                8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
        };

        // Multiply by x modulo the AES polynomial
        function automatic aesByteT aesDouble(input aesByteT value);
                return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00);
        endfunction

endpackage

// File: source/blockLoader.sv
`timescale 1ns/1ns
`include "aes_config.svh"

module blockLoader (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   keyEnable,
        input  aesTypesPkg::aesWordT   keyWord,
        input  logic                   textEnable,
        input  aesTypesPkg::aesWordT   textWord,
        output logic                   blockValid,
        output logic                   blockStart,
        output aesTypesPkg::aesStateT  blockState,
        output aesTypesPkg::aesStateT  roundKeys [2]
);

        localparam int wordBits = $clog2(`AES_BLOCK_WORDS);
        localparam int keyBits = $clog2(`AES_KEY_WORDS);

        logic [keyBits-1:0]  keyCount;
        logic [wordBits-1:0] wordCount;
        logic                keyLoaded;
        logic                lastKeyWord;
        logic                lastTextWord;

        assign lastKeyWord = keyEnable && (keyCount == keyBits'(`AES_KEY_WORDS - 1));
        assign lastTextWord = textEnable && (wordCount == wordBits'(`AES_BLOCK_WORDS - 1));

        // Clears cipherDone at the same edge as the first word lands
        assign blockStart = textEnable && (wordCount == '0);

        ////////////////////////////////////////////////////////////
        // Slot counters
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        keyCount <= '0;
                        wordCount <= '0;
                        keyLoaded <= 1'b0;
                        blockValid <= 1'b0;
                end else begin
                        // Both counters wrap, a ninth key word starts a new key
                        if (keyEnable) begin
                                keyCount <= keyCount + 1'b1;
                        end
                        if (textEnable) begin
                                wordCount <= wordCount + 1'b1;
                        end
                        if (lastKeyWord) begin
                                keyLoaded <= 1'b1;
                        end
                        blockValid <= lastTextWord;
                end
        end

        ////////////////////////////////////////////////////////////
        // Key store and block columns
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (keyEnable) begin
                        roundKeys[keyCount[keyBits-1:wordBits]].cols[keyCount[wordBits-1:0]]
                                <= keyWord;
                end
                if (textEnable) begin
                        blockState.cols[wordCount] <= textWord;
                end
        end

        // One strobe per cycle
        assert property (@(posedge clk) disable iff (!rst) !(keyEnable && textEnable));

        // Text only once a full key has arrived
        assert property (@(posedge clk) disable iff (!rst) textEnable |-> keyLoaded);

endmodule

// File: source/roundCore.sv
`timescale 1ns/1ns
`include "aes_config.svh"

module roundCore (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   blockValid,
        input  aesTypesPkg::aesStateT  blockState,
        input  aesTypesPkg::aesStateT  roundKeys [2],
        output logic                   resultValid,
        output aesTypesPkg::aesStateT  resultState
);

        import aesTypesPkg::*;
        import aesTablesPkg::*;

        localparam int stateBytes = `AES_BLOCK_WORDS * `AES_WORD_W / 8;
        localparam int rows = `AES_WORD_W / 8;

        logic     s1Valid;
        logic     s2Valid;
        aesStateT keyed;
        aesStateT subState;
        aesStateT shifted;
        aesStateT mixed;
        aesStateT s1State;
        aesStateT s1Key;
        aesStateT s2State;
        aesStateT s2Key;

        // One MixColumns column, row r taken from the top byte down
        function automatic aesWordT mixColumn(input aesWordT col);
                aesByteT a [rows];
                aesWordT mixedCol;
                for (int r = 0; r < rows; r++) begin
                        a[r] = col[`AES_WORD_W - 1 - 8*r -: 8];
                end
                for (int r = 0; r < rows; r++) begin
                        mixedCol[`AES_WORD_W - 1 - 8*r -: 8] = aesDouble(a[r])
                                ^ aesDouble(a[(r + 1) % rows]) ^ a[(r + 1) % rows]
                                ^ a[(r + 2) % rows] ^ a[(r + 3) % rows];
                end
                return mixedCol;
        endfunction

        ////////////////////////////////////////////////////////////
        // Stage 1, AddRoundKey 0 and SubBytes
        ////////////////////////////////////////////////////////////

        always_comb begin
                for (int c = 0; c < `AES_BLOCK_WORDS; c++) begin
                        keyed.cols[c] = blockState.cols[c] ^ roundKeys[0].cols[c];
                end
                for (int i = 0; i < stateBytes; i++) begin
                        subState.bytes[i] = aesSbox[keyed.bytes[i]];
                end
        end

        ////////////////////////////////////////////////////////////
        // Stage 2, ShiftRows and MixColumns
        ////////////////////////////////////////////////////////////

        always_comb begin
                // Row r rotates left by r columns
                for (int c = 0; c < `AES_BLOCK_WORDS; c++) begin
                        for (int r = 0; r < rows; r++) begin
                                shifted.bytes[rows*c + r] =
                                        s1State.bytes[rows*((c + r) % `AES_BLOCK_WORDS) + r];
                        end
                end
                for (int c = 0; c < `AES_BLOCK_WORDS; c++) begin
                        mixed.cols[c] = mixColumn(shifted.cols[c]);
                end
        end

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        s1Valid <= 1'b0;
                        s2Valid <= 1'b0;
                        resultValid <= 1'b0;
                end else begin
                        s1Valid <= blockValid;
                        s2Valid <= s1Valid;
                        resultValid <= s2Valid;
                end
        end

        // Round key 1 rides along with its block
        always_ff @(posedge clk) begin
                if (blockValid) begin
                        s1State <= subState;
                        s1Key <= roundKeys[1];
                end
                if (s1Valid) begin
                        s2State <= mixed;
                        s2Key <= s1Key;
                end
                // Stage 3, AddRoundKey 1
                if (s2Valid) begin
                        for (int c = 0; c < `AES_BLOCK_WORDS; c++) begin
                                resultState.cols[c] <= s2State.cols[c] ^ s2Key.cols[c];
                        end
                end
        end

        // Fixed latency in both directions
        assert property (@(posedge clk) disable iff (!rst)
                blockValid |-> ##(`AES_PIPE_STAGES) resultValid);
        assert property (@(posedge clk) disable iff (!rst)
                resultValid |-> $past(blockValid, `AES_PIPE_STAGES));

endmodule

// File: source/cipherOutput.sv
`timescale 1ns/1ns

module cipherOutput (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   resultValid,
        input  aesTypesPkg::aesStateT  resultState,
        input  logic                   blockStart,
        output logic                   cipherDone,
        output aesTypesPkg::aesStateT  cipherText
);

        // Done holds until the next block begins
        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        cipherDone <= 1'b0;
                end else if (resultValid) begin
                        cipherDone <= 1'b1;
                end else if (blockStart) begin
                        cipherDone <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (resultValid) begin
                        cipherText <= resultState;
                end
        end

        // Loading and the pipeline keep these apart
        assert property (@(posedge clk) disable iff (!rst) !(resultValid && blockStart));

endmodule

// File: source/aesRoundTop.sv
`timescale 1ns/1ns

module aesRoundTop (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   keyEnable,
        input  aesTypesPkg::aesWordT   keyWord,
        input  logic                   textEnable,
        input  aesTypesPkg::aesWordT   textWord,
        output logic                   cipherDone,
        output aesTypesPkg::aesStateT  cipherText
);

        import aesTypesPkg::*;

        logic     blockValid;
        logic     blockStart;
        aesStateT blockState;
        aesStateT roundKeys [2];
        logic     resultValid;
        aesStateT resultState;

        ////////////////////////////////////////////////////////////
        // Input side, round pipeline, output side
        ////////////////////////////////////////////////////////////

        blockLoader loader (
                .clk(clk),
                .rst(rst),
                .keyEnable(keyEnable),
                .keyWord(keyWord),
                .textEnable(textEnable),
                .textWord(textWord),
                .blockValid(blockValid),
                .blockStart(blockStart),
                .blockState(blockState),
                .roundKeys(roundKeys)
        );

        roundCore core (
                .clk(clk),
                .rst(rst),
                .blockValid(blockValid),
                .blockState(blockState),
                .roundKeys(roundKeys),
                .resultValid(resultValid),
                .resultState(resultState)
        );

        cipherOutput outputSide (
                .clk(clk),
                .rst(rst),
                .resultValid(resultValid),
                .resultState(resultState),
                .blockStart(blockStart),
                .cipherDone(cipherDone),
                .cipherText(cipherText)
        );

endmodule

// File: bench/aesRoundModel.svh
`ifndef AES_ROUND_MODEL_SVH
`define AES_ROUND_MODEL_SVH

// Byte times x in GF(2^8), reduced by the AES polynomial
function automatic logic [7:0] timesTwo(input logic [7:0] value);
        logic [7:0] shifted;
        shifted = {value[6:0], 1'b0};
        if (value[7]) begin
                shifted = shifted ^ 8'h1b;
        end
        return shifted;
endfunction

// AddRoundKey 0, SubBytes, ShiftRows, MixColumns, AddRoundKey 1
function automatic logic [127:0] roundReference(
                input logic [31:0] keyW [`AES_KEY_WORDS],
                input logic [31:0] textW [`AES_BLOCK_WORDS]);
        logic [7:0]   sub [4][4];
        logic [7:0]   col [4];
        logic [127:0] result;
        // Indexed [column][row], row 0 is the top byte of a word
        for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                        sub[c][r] = aesSbox[textW[c][31 - 8*r -: 8] ^ keyW[c][31 - 8*r -: 8]];
                end
        end
        for (int c = 0; c < 4; c++) begin
                // Row r of this column comes from column c + r
                for (int r = 0; r < 4; r++) begin
                        col[r] = sub[(c + r) % 4][r];
                end
                for (int r = 0; r < 4; r++) begin
                        result[127 - 32*c - 8*r -: 8] = timesTwo(col[r])
                                ^ timesTwo(col[(r + 1) % 4]) ^ col[(r + 1) % 4]
                                ^ col[(r + 2) % 4] ^ col[(r + 3) % 4]
                                ^ keyW[`AES_KEY_WORDS/2 + c][31 - 8*r -: 8];
                end
        end
        return result;
endfunction

`endif

// File: bench/tbAesRound.sv
`timescale 1ns/1ns
`include "aes_config.svh"

module tbAesRound;

        import aesTablesPkg::*;

        localparam int randomBlocks = 40;
        localparam int burstBlocks = 8;
        localparam int totalBlocks = randomBlocks + burstBlocks + 1;
        // Key and text words of every block at the worst gap, plus slack
        localparam int watchdogCycles = totalBlocks * (8 + 4) * 4 + 200;

        logic         clk = 1'b0;
        logic         rst;
        logic         keyEnable;
        logic [31:0]  keyWord;
        logic         textEnable;
        logic [31:0]  textWord;
        logic         cipherDone;
        logic [127:0] cipherText;

        logic [31:0]  keyWords [`AES_KEY_WORDS];
        logic [127:0] expected [$];

        `include "aesRoundModel.svh"

        always #10 clk = ~clk;

        aesRoundTop UUT (
                .clk(clk),
                .rst(rst),
                .keyEnable(keyEnable),
                .keyWord(keyWord),
                .textEnable(textEnable),
                .textWord(textWord),
                .cipherDone(cipherDone),
                .cipherText(cipherText)
        );

        ////////////////////////////////////////////////////////////
        // Reporting
        ////////////////////////////////////////////////////////////

        task automatic failRun(input string reason);
                $display("%s", reason);
                $display("Simulation failed");
                $fatal(1, "Run stopped at the first failure");
        endtask

        task automatic checkValue(input string name, input logic [127:0] got,
                        input logic [127:0] exp);
                if (got !== exp) begin
                        failRun($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
                                name, got, exp));
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Word drivers, all changes on the falling edge
        ////////////////////////////////////////////////////////////

        task automatic idle(input int cycles);
                keyEnable = 1'b0;
                textEnable = 1'b0;
                repeat (cycles) @(negedge clk);
        endtask

        task automatic pushKey(input logic [31:0] word);
                textEnable = 1'b0;
                keyEnable = 1'b1;
                keyWord = word;
                @(negedge clk);
        endtask

        task automatic pushText(input logic [31:0] word);
                keyEnable = 1'b0;
                textEnable = 1'b1;
                textWord = word;
                @(negedge clk);
        endtask

        task automatic loadKey(input bit expectIdle);
                int gap;
                for (int i = 0; i < `AES_KEY_WORDS; i++) begin
                        gap = int'($urandom_range(3, 0));
                        if (gap > 0) begin
                                idle(gap);
                        end
                        if (expectIdle) begin
                                checkValue("cipherDone", 128'(cipherDone), 128'(1'b0));
                        end
                        keyWords[i] = $urandom;
                        pushKey(keyWords[i]);
                end
                idle(0);
        endtask

        // Done from the last block must hold until the first word lands
        task automatic sendBlock(input bit backToBack, input bit donePending);
                logic [31:0] words [`AES_BLOCK_WORDS];
                int gap;
                for (int i = 0; i < `AES_BLOCK_WORDS; i++) begin
                        words[i] = $urandom;
                end
                for (int i = 0; i < `AES_BLOCK_WORDS; i++) begin
                        gap = backToBack ? 0 : int'($urandom_range(3, 0));
                        if (gap > 0) begin
                                idle(gap);
                        end
                        if (i == 0 && donePending) begin
                                checkValue("cipherDone", 128'(cipherDone), 128'(1'b1));
                        end
                        pushText(words[i]);
                        if (i == 0) begin
                                checkValue("cipherDone", 128'(cipherDone), 128'(1'b0));
                        end
                end
                expected.push_back(roundReference(keyWords, words));
        endtask

        task automatic waitForResult();
                int cycles;
                cycles = 0;
                while (cipherDone !== 1'b1) begin
                        if (cycles > 4 * `AES_PIPE_STAGES) begin
                                failRun("cipherDone never rose after the fourth text word");
                        end else begin
                                @(negedge clk);
                                cycles++;
                        end
                end
                checkValue("cipherDone latency", 128'(cycles), 128'(`AES_PIPE_STAGES + 1));
                checkValue("cipherText", cipherText, expected.pop_front());
        endtask

        ////////////////////////////////////////////////////////////
        // Test sequence
        ////////////////////////////////////////////////////////////

        initial begin
                void'($urandom(56));
                rst = 1'b0;
                keyEnable = 1'b0;
                keyWord = '0;
                textEnable = 1'b0;
                textWord = '0;
                repeat (5) @(negedge clk);
                rst = 1'b1;
                checkValue("cipherDone", 128'(cipherDone), 128'(1'b0));
                loadKey(1'b1);

                for (int b = 0; b < randomBlocks; b++) begin
                        sendBlock(1'b0, b > 0);
                        idle(0);
                        waitForResult();
                end

                // Each result lands as the next block's last word is sampled
                for (int b = 0; b < burstBlocks; b++) begin
                        sendBlock(1'b1, b != 1);
                        if (b > 0) begin
                                checkValue("cipherDone", 128'(cipherDone), 128'(1'b1));
                                checkValue("cipherText", cipherText, expected.pop_front());
                        end
                end
                idle(`AES_PIPE_STAGES + 1);
                checkValue("cipherDone", 128'(cipherDone), 128'(1'b1));
                checkValue("cipherText", cipherText, expected.pop_front());

                // Fresh key, one more block
                loadKey(1'b0);
                sendBlock(1'b0, 1'b1);
                idle(0);
                waitForResult();

                $display("Simulation completed successfully");
                $finish;
        end

        initial begin
                #(watchdogCycles * 20);
                failRun("Timeout: the test sequence did not finish in time");
        end

endmodule

// File: project.f
+incdir+source
+incdir+bench
source/aesTypesPkg.sv
source/aesTablesPkg.sv
source/blockLoader.sv
source/roundCore.sv
source/cipherOutput.sv
source/aesRoundTop.sv
bench/tbAesRound.sv

// File: run.sh
#!/bin/bash
# Build and run the AES round testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f project.f --top-module tbAesRound \
    --Mdir "$BUILD" -o simAesRound
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/simAesRound" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL: pass message not found in $LOG"
exit 1
